// File: src.f
+incdir+design
design/vex_pkg.sv
design/vex_decoder.sv
design/vex_logic_alu.sv
design/vex_arith_alu.sv
design/vex_perm_alu.sv
design/vex_exe_alu.sv
design/vex_top.sv
test/vex_checker.sv
test/vex_tb.sv

// File: test/vex_tb.sv
/*
 * Vector execute stage testbench
 * LFSR stimulus, reference model and in-order result scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

`include "vex_defines.svh"

module vex_tb;
    import vex_pkg::*;

    localparam int NUM_CYCLES  = 800;
    localparam int DRAIN_LIMIT = 20;

    logic        clk;
    logic        rst_n;
    logic        issue;
    vex_opcode_e opcode;
    vex_osize_e  osize;
    vex_vec_u    srca;
    vex_vec_u    srcb;
    vex_scalar_t scalar_in;
    logic        result_valid;
    vex_vec_u    vec_result;
    vex_scalar_t int_result;

    logic [15:0] lfsr_state;
    int          cycle;
    int          op_count;
    int          errors;
    int          checks;

    // Outstanding operations, oldest first
    logic [`VEX_VLEN-1:0] exp_vec_q[$];
    vex_scalar_t          exp_int_q[$];
    int                   exp_cyc_q[$];
    string                exp_name_q[$];

    vex_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .opcode       (opcode),
        .osize        (osize),
        .srca         (srca),
        .srcb         (srcb),
        .scalar_in    (scalar_in),
        .result_valid (result_valid),
        .vec_result   (vec_result),
        .int_result   (int_result)
    );

    bind vex_decoder vex_checker checker_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits       = {bits[62:0], fb};
        end
        return bits;
    endfunction

    function automatic int size_bits(input vex_osize_e sz);
        case (sz)
            E8:      return 8;
            E16:     return 16;
            default: return 32;
        endcase
    endfunction

    // ea and eb hold one element, zero-extended; the caller masks the result
    function automatic logic [31:0] elem_result(input vex_opcode_e op, input int w,
                                                input logic [31:0] ea, input logic [31:0] eb,
                                                input logic [31:0] sc);
        longint sa;
        longint sb;
        int     sh;
        sa = ea;
        sb = eb;
        if (ea[w-1]) sa = sa - (64'sd1 <<< w);
        if (eb[w-1]) sb = sb - (64'sd1 <<< w);
        sh = eb[4:0] % w;
        case (op)
            AND:     return ea & eb;
            OR:      return ea | eb;
            XOR:     return ea ^ eb;
            SLL:     return ea << sh;
            SRL:     return ea >> sh;
            SRA:     return 32'(sa >>> sh);
            ADD:     return ea + eb;
            SUB:     return ea - eb;
            MIN:     return (sa < sb) ? ea : eb;
            MAX:     return (sa < sb) ? eb : ea;
            MINU:    return (ea < eb) ? ea : eb;
            MAXU:    return (ea < eb) ? eb : ea;
            SEQ:     return (ea == eb) ? 32'd1 : 32'd0;
            SLT:     return (sa < sb) ? 32'd1 : 32'd0;
            I2V:     return sc;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [`VEX_VLEN-1:0] expected_vec(input vex_opcode_e op,
                                                          input vex_osize_e sz,
                                                          input logic [`VEX_VLEN-1:0] a,
                                                          input logic [`VEX_VLEN-1:0] b,
                                                          input vex_scalar_t sc);
        int                   w;
        logic [31:0]          mask;
        logic [31:0]          ea;
        logic [31:0]          eb;
        logic [`VEX_VLEN-1:0] lane;
        logic [`VEX_VLEN-1:0] out;
        w    = size_bits(sz);
        mask = 32'hffff_ffff >> (32 - w);
        out  = '0;
        for (int i = 0; i < `VEX_VLEN / w; i++) begin
            ea   = a >> (i * w);
            eb   = b >> (i * w);
            lane = elem_result(op, w, ea & mask, eb & mask, sc) & mask;
            out  = out | (lane << (i * w));
        end
        return out;
    endfunction

    // Element 0 with sign fill, only for V2I
    function automatic vex_scalar_t extract_elem0(input vex_opcode_e op, input vex_osize_e sz,
                                                  input logic [`VEX_VLEN-1:0] a);
        int          w;
        logic [31:0] e0;
        w  = size_bits(sz);
        e0 = a[31:0];
        if (op != V2I) return '0;
        for (int k = w; k < 32; k++) begin
            e0[k] = e0[w-1];
        end
        return e0;
    endfunction

    task automatic drive_random();
        logic [`VEX_VLEN-1:0] a;
        logic [`VEX_VLEN-1:0] b;
        logic [7:0]           same;
        a    = rand_bits(64);
        b    = rand_bits(64);
        same = rand_bits(8);
        // Some srcb elements copied from srca so SEQ and min/max ties vary per element
        case (rand_bits(2))
            0: b = a;
            1: begin
                for (int j = 0; j < `VEX_VLEN / 8; j++) begin
                    if (same[j]) b[j*8 +: 8] = a[j*8 +: 8];
                end
            end
            2: begin
                for (int j = 0; j < `VEX_VLEN / 32; j++) begin
                    if (same[j]) b[j*32 +: 32] = a[j*32 +: 32];
                end
            end
            default: ;
        endcase
        issue     <= (rand_bits(2) != 0);
        opcode    <= vex_opcode_e'(rand_bits(4));
        osize     <= vex_osize_e'(rand_bits(2));
        srca      <= a;
        srcb      <= b;
        scalar_in <= rand_bits(32);
    endtask

    task automatic check_result();
        logic [`VEX_VLEN-1:0] exp_vec;
        vex_scalar_t          exp_int;
        int                   exp_cyc;
        string                name;
        if (exp_vec_q.size() == 0) begin
            errors++;
            $display("Result at cycle %0d with no operation outstanding", cycle);
            return;
        end
        exp_vec = exp_vec_q.pop_front();
        exp_int = exp_int_q.pop_front();
        exp_cyc = exp_cyc_q.pop_front();
        name    = exp_name_q.pop_front();
        checks++;
        if (cycle != exp_cyc + 2) begin
            errors++;
            $display("[FAIL] %s result cycle expected %0d actual %0d",
                     name, exp_cyc + 2, cycle);
        end
        if (vec_result !== exp_vec) begin
            errors++;
            $display("[FAIL] %s vec_result expected %h actual %h", name, exp_vec, vec_result);
        end
        if (int_result !== exp_int) begin
            errors++;
            $display("[FAIL] %s int_result expected %h actual %h", name, exp_int, int_result);
        end
    endtask

    // Scoreboard samples on the falling edge between driving edges
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (rst_n === 1'b1 && result_valid === 1'b1) begin
            check_result();
        end
        if (rst_n === 1'b1 && issue === 1'b1) begin
            op_count++;
            exp_vec_q.push_back(expected_vec(opcode, osize, srca, srcb, scalar_in));
            exp_int_q.push_back(extract_elem0(opcode, osize, srca));
            exp_cyc_q.push_back(cycle);
            exp_name_q.push_back($sformatf("op%0d_%s_%s", op_count, opcode.name(), osize.name()));
        end
    end

    initial begin
        lfsr_state = 16'd55673;
        cycle      = 0;
        op_count   = 0;
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        issue      = 1'b0;
        opcode     = AND;
        osize      = E8;
        srca       = '0;
        srcb       = '0;
        scalar_in  = '0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Nothing issued yet, so all outputs stay at zero
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (result_valid !== 1'b0 || vec_result !== '0 || int_result !== '0) begin
                errors++;
                $display("[FAIL] idle_after_reset expected 0/0/0 actual %b/%h/%h",
                         result_valid, vec_result, int_result);
            end
        end

        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        issue <= 1'b0;

        for (int t = 0; t < DRAIN_LIMIT && exp_vec_q.size() > 0; t++) begin
            @(posedge clk);
        end
        if (exp_vec_q.size() > 0) begin
            errors++;
            $display("Timed out with %0d results never returned", exp_vec_q.size());
        end
        // Idle window to catch any extra result_valid
        repeat (4) @(posedge clk);

        $display("Operations %0d, checks %0d, errors %0d", op_count, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/vex_checker.sv
/*
 * Decoder timing checker
 * Concurrent assertions on issue latency, strobe exclusivity and reset
 */
`timescale 1ns/1ps
`default_nettype none

module vex_checker (
    input logic clk,
    input logic rst_n,
    input logic issue,
    input logic exe_valid,
    input logic result_valid,
    input logic is_and, is_or, is_xor,
    input logic is_shift, is_left, is_arith,
    input logic is_add, is_sub, is_min, is_max, is_signed,
    input logic is_set_equal, is_set_less,
    input logic is_i2v, is_v2i
);
    logic [11:0] op_class;
    logic [14:0] strobes;

    // Modifier strobes stay out of the class vector
    assign op_class = {is_and, is_or, is_xor, is_shift, is_add, is_sub,
                       is_min, is_max, is_set_equal, is_set_less, is_i2v, is_v2i};
    assign strobes  = {op_class, is_left, is_arith, is_signed};

    issue_to_result: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> ##2 result_valid)
        else $error("result_valid not high two cycles after issue");

    result_from_issue: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(issue, 2))
        else $error("result_valid high without an issue two cycles earlier");

    one_class: assert property (@(posedge clk) disable iff (!rst_n)
        exe_valid |-> $onehot0(op_class))
        else $error("more than one operation class strobe set");

    // All control low from the second reset cycle on
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> (strobes == '0) && !exe_valid && !result_valid)
        else $error("decoder control active during reset");

endmodule

`default_nettype wire

// File: design/vex_top.sv
/*
 * Vector execute stage top
 * Decoder and execute block, two cycles from issue to result
 */
`timescale 1ns/1ps
`default_nettype none

module vex_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  vex_pkg::vex_opcode_e opcode,
    input  vex_pkg::vex_osize_e  osize,
    input  vex_pkg::vex_vec_u    srca,
    input  vex_pkg::vex_vec_u    srcb,
    input  vex_pkg::vex_scalar_t scalar_in,
    output logic                 result_valid,
    output vex_pkg::vex_vec_u    vec_result,
    output vex_pkg::vex_scalar_t int_result
);
    import vex_pkg::*;

    // Decoded strobes into the execute block
    logic is_and, is_or, is_xor;
    logic is_shift, is_left, is_arith;
    logic is_add, is_sub, is_min, is_max, is_signed;
    logic is_set_equal, is_set_less;
    logic is_i2v, is_v2i;

    vex_osize_e osize_exe;
    logic       exe_valid;

    // Port names match the nets one to one
    vex_decoder decoder_i (.*);

    vex_exe_alu exe_alu_i (.*);

endmodule

`default_nettype wire

// File: design/vex_exe_alu.sv
/*
 * Vector execute block
 * Operand registers, the three ALUs, OR combine and result registers
 */
`timescale 1ns/1ps
`default_nettype none

module vex_exe_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  logic                 exe_valid,
    input  logic                 is_and,
    input  logic                 is_or,
    input  logic                 is_xor,
    input  logic                 is_shift,
    input  logic                 is_left,
    input  logic                 is_arith,
    input  logic                 is_add,
    input  logic                 is_sub,
    input  logic                 is_min,
    input  logic                 is_max,
    input  logic                 is_signed,
    input  logic                 is_set_equal,
    input  logic                 is_set_less,
    input  logic                 is_i2v,
    input  logic                 is_v2i,
    input  vex_pkg::vex_osize_e  osize_exe,
    input  vex_pkg::vex_vec_u    srca,
    input  vex_pkg::vex_vec_u    srcb,
    input  vex_pkg::vex_scalar_t scalar_in,
    output vex_pkg::vex_vec_u    vec_result,
    output vex_pkg::vex_scalar_t int_result
);
    import vex_pkg::*;

    vex_vec_u    srca_q;
    vex_vec_u    srcb_q;
    vex_scalar_t scalar_q;

    vex_vec_u    logic_res;
    vex_vec_u    arith_res;
    vex_vec_u    perm_res;
    vex_scalar_t perm_int;
    vex_vec_u    vec_comb;

    // Operand capture
    always_ff @(posedge clk) begin
        if (issue) begin
            srca_q   <= srca;
            srcb_q   <= srcb;
            scalar_q <= scalar_in;
        end
    end

    vex_logic_alu logic_alu_i (
        .is_and   (is_and),
        .is_or    (is_or),
        .is_xor   (is_xor),
        .is_shift (is_shift),
        .is_left  (is_left),
        .is_arith (is_arith),
        .osize    (osize_exe),
        .srca     (srca_q),
        .srcb     (srcb_q),
        .result   (logic_res)
    );

    vex_arith_alu arith_alu_i (
        .is_add       (is_add),
        .is_sub       (is_sub),
        .is_min       (is_min),
        .is_max       (is_max),
        .is_signed    (is_signed),
        .is_set_equal (is_set_equal),
        .is_set_less  (is_set_less),
        .osize        (osize_exe),
        .srca         (srca_q),
        .srcb         (srcb_q),
        .result       (arith_res)
    );

    vex_perm_alu perm_alu_i (
        .is_i2v       (is_i2v),
        .is_v2i       (is_v2i),
        .osize        (osize_exe),
        .srca         (srca_q),
        .scalar       (scalar_q),
        .vector_data  (perm_res),
        .integer_data (perm_int)
    );

    // Unselected ALUs drive zero
    assign vec_comb.data = logic_res.data | arith_res.data | perm_res.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vec_result <= '0;
            int_result <= '0;
        end else if (exe_valid) begin
            vec_result <= vec_comb;
            int_result <= perm_int;
        end
    end

endmodule

`default_nettype wire

// File: design/vex_perm_alu.sv
/*
 * Vector permutation ALU
 * Scalar broadcast into a vector and element 0 extract to a scalar
 */
`timescale 1ns/1ps
`default_nettype none

`include "vex_defines.svh"

module vex_perm_alu (
    input  logic                is_i2v,
    input  logic                is_v2i,
    input  vex_pkg::vex_osize_e  osize,
    input  vex_pkg::vex_vec_u   srca,
    input  vex_pkg::vex_scalar_t scalar,
    output vex_pkg::vex_vec_u   vector_data,
    output vex_pkg::vex_scalar_t integer_data
);
    import vex_pkg::*;

    always_comb begin
        vector_data  = '0;
        integer_data = '0;
        if (is_i2v) begin
            case (osize)
                E8: begin
                    for (int i = 0; i < `VEX_NUM_E8; i++) begin
                        vector_data.e8[i] = scalar[7:0];
                    end
                end
                E16: begin
                    for (int i = 0; i < `VEX_NUM_E16; i++) begin
                        vector_data.e16[i] = scalar[15:0];
                    end
                end
                default: begin
                    for (int i = 0; i < `VEX_NUM_E32; i++) begin
                        vector_data.e32[i] = scalar[31:0];
                    end
                end
            endcase
        end
        // Sign extension of element 0
        if (is_v2i) begin
            case (osize)
                E8:      integer_data = {{(`VEX_XLEN-8){srca.e8[0][7]}}, srca.e8[0]};
                E16:     integer_data = {{(`VEX_XLEN-16){srca.e16[0][15]}}, srca.e16[0]};
                default: integer_data = srca.e32[0];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/vex_arith_alu.sv
/*
 * Vector arithmetic ALU
 * Per-element add, subtract, min/max and set compares
 */
`timescale 1ns/1ps
`default_nettype none

`include "vex_defines.svh"

module vex_arith_alu (
    input  logic               is_add,
    input  logic               is_sub,
    input  logic               is_min,
    input  logic               is_max,
    input  logic               is_signed,
    input  logic               is_set_equal,
    input  logic               is_set_less,
    input  vex_pkg::vex_osize_e osize,
    input  vex_pkg::vex_vec_u  srca,
    input  vex_pkg::vex_vec_u  srcb,
    output vex_pkg::vex_vec_u  result
);
    import vex_pkg::*;

    // Operands come in extended to 33 bits, so the difference never overflows
    // and its top bit is the less-than flag for either signedness
    function automatic logic [31:0] elem_op(input logic [32:0] a,
                                            input logic [32:0] b);
        logic [32:0] sum;
        logic [32:0] diff;
        logic        less;
        logic [31:0] res;
        sum  = a + b;
        diff = a - b;
        less = diff[32];
        res  = '0;
        if (is_add)       res = sum[31:0];
        if (is_sub)       res = diff[31:0];
        if (is_min)       res = less ? a[31:0] : b[31:0];
        if (is_max)       res = less ? b[31:0] : a[31:0];
        if (is_set_equal) res = {31'b0, diff == '0};
        if (is_set_less)  res = {31'b0, less};
        return res;
    endfunction

    always_comb begin
        logic [32:0] ext_a;
        logic [32:0] ext_b;
        logic [31:0] elem;
        ext_a  = '0;
        ext_b  = '0;
        elem   = '0;
        result = '0;
        case (osize)
            E8: begin
                for (int i = 0; i < `VEX_NUM_E8; i++) begin
                    ext_a         = {{25{is_signed & srca.e8[i][7]}}, srca.e8[i]};
                    ext_b         = {{25{is_signed & srcb.e8[i][7]}}, srcb.e8[i]};
                    elem          = elem_op(ext_a, ext_b);
                    result.e8[i]  = elem[7:0];
                end
            end
            E16: begin
                for (int i = 0; i < `VEX_NUM_E16; i++) begin
                    ext_a         = {{17{is_signed & srca.e16[i][15]}}, srca.e16[i]};
                    ext_b         = {{17{is_signed & srcb.e16[i][15]}}, srcb.e16[i]};
                    elem          = elem_op(ext_a, ext_b);
                    result.e16[i] = elem[15:0];
                end
            end
            default: begin
                for (int i = 0; i < `VEX_NUM_E32; i++) begin
                    ext_a         = {is_signed & srca.e32[i][31], srca.e32[i]};
                    ext_b         = {is_signed & srcb.e32[i][31], srcb.e32[i]};
                    result.e32[i] = elem_op(ext_a, ext_b);
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/vex_logic_alu.sv
/*
 * Vector logical ALU
 * Bitwise AND/OR/XOR and per-element shifts
 */
`timescale 1ns/1ps
`default_nettype none

`include "vex_defines.svh"

module vex_logic_alu (
    input  logic               is_and,
    input  logic               is_or,
    input  logic               is_xor,
    input  logic               is_shift,
    input  logic               is_left,
    input  logic               is_arith,
    input  vex_pkg::vex_osize_e osize,
    input  vex_pkg::vex_vec_u  srca,
    input  vex_pkg::vex_vec_u  srcb,
    output vex_pkg::vex_vec_u  result
);
    import vex_pkg::*;

    // Operand arrives already extended to 32 bits
    function automatic logic [31:0] shift_elem(input logic [31:0] value,
                                               input logic [4:0]  amount);
        if (is_left) begin
            return value << amount;
        end
        if (is_arith) begin
            return $signed(value) >>> amount;
        end
        return value >> amount;
    endfunction

    always_comb begin
        logic [31:0] ext;
        logic [31:0] shifted;
        ext     = '0;
        shifted = '0;
        result  = '0;
        if (is_and) result.data = srca.data & srcb.data;
        if (is_or)  result.data = srca.data | srcb.data;
        if (is_xor) result.data = srca.data ^ srcb.data;
        if (is_shift) begin
            case (osize)
                E8: begin
                    for (int i = 0; i < `VEX_NUM_E8; i++) begin
                        ext           = {{24{is_arith & srca.e8[i][7]}}, srca.e8[i]};
                        shifted       = shift_elem(ext, {2'b00, srcb.e8[i][2:0]});
                        result.e8[i]  = shifted[7:0];
                    end
                end
                E16: begin
                    for (int i = 0; i < `VEX_NUM_E16; i++) begin
                        ext           = {{16{is_arith & srca.e16[i][15]}}, srca.e16[i]};
                        shifted       = shift_elem(ext, {1'b0, srcb.e16[i][3:0]});
                        result.e16[i] = shifted[15:0];
                    end
                end
                default: begin
                    for (int i = 0; i < `VEX_NUM_E32; i++) begin
                        result.e32[i] = shift_elem(srca.e32[i], srcb.e32[i][4:0]);
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/vex_decoder.sv
/*
 * Vector execute control
 * Decodes the opcode into operation strobes and pipes the valid bits
 */
`timescale 1ns/1ps
`default_nettype none

module vex_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  vex_pkg::vex_opcode_e opcode,
    input  vex_pkg::vex_osize_e  osize,
    output logic                 is_and,
    output logic                 is_or,
    output logic                 is_xor,
    output logic                 is_shift,
    output logic                 is_left,
    output logic                 is_arith,
    output logic                 is_add,
    output logic                 is_sub,
    output logic                 is_min,
    output logic                 is_max,
    output logic                 is_signed,
    output logic                 is_set_equal,
    output logic                 is_set_less,
    output logic                 is_i2v,
    output logic                 is_v2i,
    output vex_pkg::vex_osize_e  osize_exe,
    output logic                 exe_valid,
    output logic                 result_valid
);
    import vex_pkg::*;

    logic dec_and, dec_or, dec_xor;
    logic dec_shift, dec_left, dec_arith;
    logic dec_add, dec_sub, dec_min, dec_max, dec_signed;
    logic dec_set_equal, dec_set_less;
    logic dec_i2v, dec_v2i;

    // Strobes stay low on cycles without an issue
    always_comb begin
        dec_and       = 1'b0;
        dec_or        = 1'b0;
        dec_xor       = 1'b0;
        dec_shift     = 1'b0;
        dec_left      = 1'b0;
        dec_arith     = 1'b0;
        dec_add       = 1'b0;
        dec_sub       = 1'b0;
        dec_min       = 1'b0;
        dec_max       = 1'b0;
        dec_signed    = 1'b0;
        dec_set_equal = 1'b0;
        dec_set_less  = 1'b0;
        dec_i2v       = 1'b0;
        dec_v2i       = 1'b0;
        if (issue) begin
            case (opcode)
                AND:  dec_and = 1'b1;
                OR:   dec_or = 1'b1;
                XOR:  dec_xor = 1'b1;
                SLL: begin
                    dec_shift = 1'b1;
                    dec_left  = 1'b1;
                end
                SRL:  dec_shift = 1'b1;
                SRA: begin
                    dec_shift = 1'b1;
                    dec_arith = 1'b1;
                end
                ADD:  dec_add = 1'b1;
                SUB:  dec_sub = 1'b1;
                MIN: begin
                    dec_min    = 1'b1;
                    dec_signed = 1'b1;
                end
                MAX: begin
                    dec_max    = 1'b1;
                    dec_signed = 1'b1;
                end
                MINU: dec_min = 1'b1;
                MAXU: dec_max = 1'b1;
                SEQ:  dec_set_equal = 1'b1;
                SLT: begin
                    dec_set_less = 1'b1;
                    dec_signed   = 1'b1;
                end
                I2V:  dec_i2v = 1'b1;
                default: dec_v2i = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_and       <= 1'b0;
            is_or        <= 1'b0;
            is_xor       <= 1'b0;
            is_shift     <= 1'b0;
            is_left      <= 1'b0;
            is_arith     <= 1'b0;
            is_add       <= 1'b0;
            is_sub       <= 1'b0;
            is_min       <= 1'b0;
            is_max       <= 1'b0;
            is_signed    <= 1'b0;
            is_set_equal <= 1'b0;
            is_set_less  <= 1'b0;
            is_i2v       <= 1'b0;
            is_v2i       <= 1'b0;
            osize_exe    <= E8;
            exe_valid    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            is_and       <= dec_and;
            is_or        <= dec_or;
            is_xor       <= dec_xor;
            is_shift     <= dec_shift;
            is_left      <= dec_left;
            is_arith     <= dec_arith;
            is_add       <= dec_add;
            is_sub       <= dec_sub;
            is_min       <= dec_min;
            is_max       <= dec_max;
            is_signed    <= dec_signed;
            is_set_equal <= dec_set_equal;
            is_set_less  <= dec_set_less;
            is_i2v       <= dec_i2v;
            is_v2i       <= dec_v2i;
            exe_valid    <= issue;
            result_valid <= exe_valid;
            if (issue) begin
                osize_exe <= (osize == ERSVD) ? E32 : osize;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/vex_pkg.sv
/*
 * Vector execute stage types
 * Opcodes, element sizes and the vector word with its element views
 */
`default_nettype none

`include "vex_defines.svh"

package vex_pkg;

    typedef enum logic [3:0] {
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        ADD,
        SUB,
        MIN,
        MAX,
        MINU,
        MAXU,
        SEQ,
        SLT,
        I2V,
        V2I
    } vex_opcode_e;

    // Code 3 is reserved and runs as 32-bit elements
    typedef enum logic [1:0] {
        E8,
        E16,
        E32,
        ERSVD
    } vex_osize_e;

    // Element 0 sits in the low bits of every view
    typedef union packed {
        logic [`VEX_VLEN-1:0]              data;
        logic [`VEX_NUM_E8-1:0][7:0]       e8;
        logic [`VEX_NUM_E16-1:0][15:0]     e16;
        logic [`VEX_NUM_E32-1:0][31:0]     e32;
    } vex_vec_u;

    typedef logic [`VEX_XLEN-1:0] vex_scalar_t;

endpackage

`default_nettype wire

// File: design/vex_defines.svh
/*
 * Vector execute stage widths
 * Vector register and scalar sizes, element counts per size
 */
`ifndef VEX_DEFINES_SVH
`define VEX_DEFINES_SVH

// One vector register is one 64-bit word
`define VEX_VLEN 64

// Scalar integer width
`define VEX_XLEN 32

`define VEX_NUM_E8  (`VEX_VLEN/8)
`define VEX_NUM_E16 (`VEX_VLEN/16)
`define VEX_NUM_E32 (`VEX_VLEN/32)

`endif
